//--- source/beam_cfg_pkg.sv
package beam_cfg_pkg;

    // raw sample path, one beam-pair block
    localparam int NBITS     = 5;                      // signed input sample
    localparam int NSAMP     = 4;                      // samples per clock per channel
    localparam int NCHAN     = 8;                      // delayed channels per beam
    localparam int NBEAM     = 2;                      // beam A and beam B
    localparam int IN_BITS   = NCHAN * NSAMP * NBITS;  // channel-major, then sample

    // beam sum covers -128..+128 (inverting -16 gives +16)
    localparam int BEAM_BITS = 9;
    localparam int SQ_BITS   = 15;                     // unsigned square, 128*128 fits
    localparam int SQ_MAX    = 16384;                  // largest square the former can make

    // per-clock sum of four squares, then two of them make the envelope
    localparam int QUAD_BITS = 17;
    localparam int ENV_BITS  = 18;

    // how one channel enters a beam, decoded from its use/invert bits
    typedef enum logic [1:0] {
        CHAN_OFF    = 2'b00,  // use low, channel ignored
        CHAN_PASS   = 2'b01,  // added as is
        CHAN_INVERT = 2'b10   // negated before the add
    } chan_mode_e;

endpackage

//--- source/trig_ctrl_pkg.sv
package trig_ctrl_pkg;

    // threshold values compare directly against the 18-bit envelope
    localparam int THR_BITS = 18;

    // two thresholds per beam, each double-buffered
    localparam int NTHR = 2;

    // one raw trigger per beam and threshold, 2 beams x 2 thresholds
    localparam int NTRIG = 4;

    // all ones, so nothing can fire until software loads real thresholds
    localparam logic [THR_BITS-1:0] THR_RESET = '1;

endpackage

//--- source/beam_former.sv
`timescale 1ns/10ps
module beam_former (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    input  logic [beam_cfg_pkg::IN_BITS-1:0]          beam_a_i,
    input  logic [beam_cfg_pkg::NCHAN-1:0]            beam_a_use_i,
    input  logic [beam_cfg_pkg::NCHAN-1:0]            beam_a_invert_i,
    input  logic [beam_cfg_pkg::IN_BITS-1:0]          beam_b_i,
    input  logic [beam_cfg_pkg::NCHAN-1:0]            beam_b_use_i,
    input  logic [beam_cfg_pkg::NCHAN-1:0]            beam_b_invert_i,
    output logic [beam_cfg_pkg::NSAMP-1:0][beam_cfg_pkg::SQ_BITS-1:0] sq_a_o,
    output logic [beam_cfg_pkg::NSAMP-1:0][beam_cfg_pkg::SQ_BITS-1:0] sq_b_o
);
    import beam_cfg_pkg::*;

    // both beams side by side, index 0 is A, index 1 is B
    logic [NBEAM-1:0][IN_BITS-1:0]                   data;
    logic [NBEAM-1:0][NCHAN-1:0]                     use_m;
    logic [NBEAM-1:0][NCHAN-1:0]                     inv_m;

    logic [NBEAM-1:0][NSAMP-1:0][BEAM_BITS-1:0]      sum_d;  // combinational beam sum
    logic [NBEAM-1:0][NSAMP-1:0][BEAM_BITS-1:0]      sum_q;  // stage 1, two's complement
    logic [NBEAM-1:0][NSAMP-1:0][SQ_BITS-1:0]        sq_d;
    logic [NBEAM-1:0][NSAMP-1:0][SQ_BITS-1:0]        sq_q;   // stage 2

    assign data  = {beam_b_i, beam_a_i};
    assign use_m = {beam_b_use_i, beam_a_use_i};
    assign inv_m = {beam_b_invert_i, beam_a_invert_i};

    // use low wins over invert
    function automatic chan_mode_e decode_mode(input logic use_b, input logic inv_b);
        if (!use_b)
            return CHAN_OFF;
        return inv_b ? CHAN_INVERT : CHAN_PASS;
    endfunction

    // add up enabled channels sample by sample
    always_comb begin : form_sum
        logic signed [NBITS-1:0]     smp;
        logic signed [BEAM_BITS-1:0] acc;
        for (int b = 0; b < NBEAM; b++) begin
            for (int s = 0; s < NSAMP; s++) begin
                acc = '0;
                for (int c = 0; c < NCHAN; c++) begin
                    smp = signed'(data[b][(c*NSAMP + s)*NBITS +: NBITS]);  // channel-major
                    case (decode_mode(use_m[b][c], inv_m[b][c]))
                        CHAN_PASS:   acc = acc + smp;   // sign-extends to 9 bits
                        CHAN_INVERT: acc = acc - smp;   // -(-16) still fits
                        default:     acc = acc;         // off, contributes nothing
                    endcase
                end
                sum_d[b][s] = acc;
            end
        end
    end

    // square of the registered sum, always positive
    always_comb begin : form_square
        logic signed [BEAM_BITS-1:0]   val;
        logic signed [2*BEAM_BITS-1:0] prod;
        for (int b = 0; b < NBEAM; b++) begin
            for (int s = 0; s < NSAMP; s++) begin
                val         = signed'(sum_q[b][s]);
                prod        = val * val;
                sq_d[b][s]  = SQ_BITS'(prod);  // upper bits always zero, max 16384
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sum_q <= '0;
            sq_q  <= '0;
        end else begin
            sum_q <= sum_d;  // n+1
            sq_q  <= sq_d;   // n+2
        end
    end

    assign sq_a_o = sq_q[0];
    assign sq_b_o = sq_q[1];

    // the square stage never sees a sum outside +/-128
    for (genvar b = 0; b < NBEAM; b++) begin : g_beam_chk
        for (genvar s = 0; s < NSAMP; s++) begin : g_samp_chk
            a_sq_range: assert property (
                @(posedge clk_i) disable iff (rst_i)
                sq_q[b][s] <= SQ_BITS'(SQ_MAX)
            ) else $error("beam %0d sample %0d square %0d above max", b, s, sq_q[b][s]);
        end
    end

endmodule

//--- source/beam_envelope.sv
`timescale 1ns/10ps
module beam_envelope (
    input  logic                                                       clk_i,
    input  logic                                                       rst_i,
    input  logic [beam_cfg_pkg::NSAMP-1:0][beam_cfg_pkg::SQ_BITS-1:0] sq_a_i,
    input  logic [beam_cfg_pkg::NSAMP-1:0][beam_cfg_pkg::SQ_BITS-1:0] sq_b_i,
    output logic [beam_cfg_pkg::ENV_BITS-1:0]                          env_a_o,
    output logic [beam_cfg_pkg::ENV_BITS-1:0]                          env_b_o
);
    import beam_cfg_pkg::*;

    // 8-sample boxcar over two clocks of four samples,
    // only one output per clock, so decimated by four

    logic [NBEAM-1:0][NSAMP-1:0][SQ_BITS-1:0] sq;          // A at 0, B at 1
    logic [NBEAM-1:0][QUAD_BITS-1:0]          quad_d;      // sum of this clock's squares
    logic [NBEAM-1:0][QUAD_BITS-1:0]          quad_q;      // n+3
    logic [NBEAM-1:0][QUAD_BITS-1:0]          quad_prev_q; // one clock older than quad_q
    logic [NBEAM-1:0][ENV_BITS-1:0]           env_d;
    logic [NBEAM-1:0][ENV_BITS-1:0]           env_q;       // n+4

    assign sq = {sq_b_i, sq_a_i};

    // four squares at most 4*16384, needs all 17 bits
    always_comb begin
        for (int b = 0; b < NBEAM; b++) begin
            quad_d[b] = '0;
            for (int s = 0; s < NSAMP; s++)
                quad_d[b] = quad_d[b] + QUAD_BITS'(sq[b][s]);
        end
    end

    // current four plus the previous four
    always_comb begin
        for (int b = 0; b < NBEAM; b++)
            env_d[b] = ENV_BITS'(quad_q[b]) + ENV_BITS'(quad_prev_q[b]);
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            quad_q      <= '0;
            quad_prev_q <= '0;  // first two envelopes after reset see this zero
            env_q       <= '0;
        end else begin
            quad_q      <= quad_d;
            quad_prev_q <= quad_q;  // word n-1 when word n sits in quad_q
            env_q       <= env_d;
        end
    end

    // straight to the threshold stage and the observation port
    assign env_a_o = env_q[0];
    assign env_b_o = env_q[1];

    // eight full-scale squares is the ceiling,
    // anything above means a square or sum overflowed upstream
    for (genvar b = 0; b < NBEAM; b++) begin : g_env_chk
        a_env_range: assert property (
            @(posedge clk_i) disable iff (rst_i)
            env_q[b] <= ENV_BITS'(8 * SQ_MAX)
        ) else $error("beam %0d envelope %0d above eight full squares", b, env_q[b]);
    end

endmodule

//--- source/beam_threshold.sv
`timescale 1ns/10ps
module beam_threshold (
    input  logic                                                          clk_i,
    input  logic                                                          rst_i,
    input  logic [trig_ctrl_pkg::NTHR-1:0][trig_ctrl_pkg::THR_BITS-1:0]  thresh_i,
    input  logic [trig_ctrl_pkg::NTHR-1:0]                                thresh_wr_i,
    input  logic [trig_ctrl_pkg::NTHR-1:0]                                thresh_update_i,
    input  logic [beam_cfg_pkg::ENV_BITS-1:0]                             env_a_i,
    input  logic [beam_cfg_pkg::ENV_BITS-1:0]                             env_b_i,
    output logic [trig_ctrl_pkg::NTRIG-1:0]                               trigger_o
);
    import beam_cfg_pkg::*;
    import trig_ctrl_pkg::*;

    logic [NBEAM-1:0][ENV_BITS-1:0]  env;        // A at 0, B at 1
    logic [NTHR-1:0][THR_BITS-1:0]   pending_q;  // staged by write strobe
    logic [NTHR-1:0][THR_BITS-1:0]   active_q;   // used by the compare
    logic [NTRIG-1:0]                trig_d;
    logic [NTRIG-1:0]                trig_q;

    assign env = {env_b_i, env_a_i};

    // double buffer per slot
    // same-cycle write and update: active takes the old pending,
    // the new write lands in pending for a later update
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= {NTHR{THR_RESET}};
            active_q  <= {NTHR{THR_RESET}};
        end else begin
            for (int j = 0; j < NTHR; j++) begin
                if (thresh_update_i[j])
                    active_q[j] <= pending_q[j];  // value before this edge
                if (thresh_wr_i[j])
                    pending_q[j] <= thresh_i[j];
            end
        end
    end

    // bit order: thr0 A, thr0 B, thr1 A, thr1 B
    always_comb begin
        for (int j = 0; j < NTHR; j++) begin
            for (int b = 0; b < NBEAM; b++)
                trig_d[j*NBEAM + b] = env[b] > active_q[j];  // strict, equal does not fire
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i)
            trig_q <= '0;
        else
            trig_q <= trig_d;  // n+5 at the top level
    end

    assign trigger_o = trig_q;

    // update pulse moves the pending value seen at that edge
    for (genvar j = 0; j < NTHR; j++) begin : g_thr_chk
        a_update_moves_pending: assert property (
            @(posedge clk_i) disable iff (rst_i)
            thresh_update_i[j] |=> active_q[j] == $past(pending_q[j])
        ) else $error("slot %0d active %0h not the staged value", j, active_q[j]);
    end

endmodule

//--- source/dual_beam_trigger.sv
`timescale 1ns/10ps
module dual_beam_trigger (
    input  logic                                                          clk_i,
    input  logic                                                          rst_i,
    // beam A channel data and per-channel masks
    input  logic [beam_cfg_pkg::IN_BITS-1:0]                              beam_a_i,
    input  logic [beam_cfg_pkg::NCHAN-1:0]                                beam_a_use_i,
    input  logic [beam_cfg_pkg::NCHAN-1:0]                                beam_a_invert_i,
    // beam B, same layout
    input  logic [beam_cfg_pkg::IN_BITS-1:0]                              beam_b_i,
    input  logic [beam_cfg_pkg::NCHAN-1:0]                                beam_b_use_i,
    input  logic [beam_cfg_pkg::NCHAN-1:0]                                beam_b_invert_i,
    // threshold config, double-buffered
    input  logic [trig_ctrl_pkg::NTHR-1:0][trig_ctrl_pkg::THR_BITS-1:0]  thresh_i,
    input  logic [trig_ctrl_pkg::NTHR-1:0]                                thresh_wr_i,
    input  logic [trig_ctrl_pkg::NTHR-1:0]                                thresh_update_i,
    output logic [trig_ctrl_pkg::NTRIG-1:0]                               trigger_o,  // n+5
    output logic [beam_cfg_pkg::ENV_BITS-1:0]                             env_a_o,    // n+4
    output logic [beam_cfg_pkg::ENV_BITS-1:0]                             env_b_o
);
    import beam_cfg_pkg::*;

    logic [NSAMP-1:0][SQ_BITS-1:0] sq_a;  // squared beam A, n+2
    logic [NSAMP-1:0][SQ_BITS-1:0] sq_b;
    logic [ENV_BITS-1:0]           env_a; // boxcar envelope, n+4
    logic [ENV_BITS-1:0]           env_b;

    // sum and square, two clocks
    beam_former u_former (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .beam_a_i        (beam_a_i),
        .beam_a_use_i    (beam_a_use_i),
        .beam_a_invert_i (beam_a_invert_i),
        .beam_b_i        (beam_b_i),
        .beam_b_use_i    (beam_b_use_i),
        .beam_b_invert_i (beam_b_invert_i),
        .sq_a_o          (sq_a),
        .sq_b_o          (sq_b)
    );

    // quad sum then two-clock boxcar
    beam_envelope u_envelope (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .sq_a_i  (sq_a),
        .sq_b_i  (sq_b),
        .env_a_o (env_a),
        .env_b_o (env_b)
    );

    // one clock of compare against the active thresholds
    beam_threshold u_threshold (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .thresh_i        (thresh_i),
        .thresh_wr_i     (thresh_wr_i),
        .thresh_update_i (thresh_update_i),
        .env_a_i         (env_a),
        .env_b_i         (env_b),
        .trigger_o       (trigger_o)
    );

    // envelopes also leave the block for observation
    assign env_a_o = env_a;
    assign env_b_o = env_b;

endmodule

//--- testbench/tb_beam_model.svh
`ifndef TB_BEAM_MODEL_SVH
`define TB_BEAM_MODEL_SVH

// reference model of one beam pair, plain integer arithmetic
// channel c, sample s of a word sits at bit (c*NSAMP + s)*NBITS

// beam value of sample s, enabled channels added, inverted ones subtracted
function automatic int model_beam_sum(input logic [IN_BITS-1:0] word,
                                      input logic [NCHAN-1:0]   use_m,
                                      input logic [NCHAN-1:0]   inv_m,
                                      input int                 s);
    logic signed [NBITS-1:0] smp;
    int                      total;
    total = 0;
    for (int c = 0; c < NCHAN; c++) begin
        smp = word[(c*NSAMP + s)*NBITS +: NBITS];
        if (use_m[c])  // use low means the channel is off
            total = inv_m[c] ? total - int'(smp) : total + int'(smp);
    end
    return total;
endfunction

function automatic int model_square(input int x);
    return x * x;  // at most 128*128
endfunction

// four squared beam samples of one clock
function automatic int model_quad(input logic [IN_BITS-1:0] word,
                                  input logic [NCHAN-1:0]   use_m,
                                  input logic [NCHAN-1:0]   inv_m);
    int total;
    total = 0;
    for (int s = 0; s < NSAMP; s++)
        total += model_square(model_beam_sum(word, use_m, inv_m, s));
    return total;
endfunction

// 8-sample boxcar, word n plus word n-1
function automatic int model_envelope(input logic [IN_BITS-1:0] new_word,
                                      input logic [NCHAN-1:0]   new_use,
                                      input logic [NCHAN-1:0]   new_inv,
                                      input logic [IN_BITS-1:0] old_word,
                                      input logic [NCHAN-1:0]   old_use,
                                      input logic [NCHAN-1:0]   old_inv);
    return model_quad(new_word, new_use, new_inv) + model_quad(old_word, old_use, old_inv);
endfunction

// bit 0 A/thr0, bit 1 B/thr0, bit 2 A/thr1, bit 3 B/thr1, strictly greater
function automatic logic [NTRIG-1:0] model_triggers(input int                  env_a,
                                                    input int                  env_b,
                                                    input logic [THR_BITS-1:0] thr0,
                                                    input logic [THR_BITS-1:0] thr1);
    logic [NTRIG-1:0] bits;
    bits[0] = env_a > int'(thr0);
    bits[1] = env_b > int'(thr0);
    bits[2] = env_a > int'(thr1);
    bits[3] = env_b > int'(thr1);
    return bits;
endfunction

`endif

//--- testbench/tb_dual_beam_trigger.sv
`timescale 1ns/10ps
module tb_dual_beam_trigger;
    import beam_cfg_pkg::*;
    import trig_ctrl_pkg::*;

    `include "tb_beam_model.svh"

    localparam int CLK_PERIOD = 100;  // ns
    localparam int RST_CYCLES = 4;
    localparam int DRIVE_DLY  = 1;    // ns after the rising edge
    localparam int SEED       = 56;
    localparam int WAIT_LIMIT = 12;   // cycles per wait loop
    localparam int HIST       = 6;    // words n..n-5, enough for the trigger latency
    localparam int TAG_NONE   = 0;
    localparam int TAG_MIRROR = 1;    // A at +15 passed, B at -15 inverted

    logic                          clk_i;
    logic                          rst_i;
    logic [IN_BITS-1:0]            beam_a_i;
    logic [NCHAN-1:0]              beam_a_use_i;
    logic [NCHAN-1:0]              beam_a_invert_i;
    logic [IN_BITS-1:0]            beam_b_i;
    logic [NCHAN-1:0]              beam_b_use_i;
    logic [NCHAN-1:0]              beam_b_invert_i;
    logic [NTHR-1:0][THR_BITS-1:0] thresh_i;
    logic [NTHR-1:0]               thresh_wr_i;
    logic [NTHR-1:0]               thresh_update_i;
    logic [NTRIG-1:0]              trigger_o;
    logic [ENV_BITS-1:0]           env_a_o;
    logic [ENV_BITS-1:0]           env_b_o;

    // history, index 0 is the word taken at the latest edge
    logic [IN_BITS-1:0] word_a_h [HIST];
    logic [NCHAN-1:0]   use_a_h  [HIST];
    logic [NCHAN-1:0]   inv_a_h  [HIST];
    logic [IN_BITS-1:0] word_b_h [HIST];
    logic [NCHAN-1:0]   use_b_h  [HIST];
    logic [NCHAN-1:0]   inv_b_h  [HIST];
    int                 tag_h    [HIST];

    logic [NTHR-1:0][THR_BITS-1:0] pend_m;      // model of the staged thresholds
    logic [NTHR-1:0][THR_BITS-1:0] act_m;       // active after the latest edge
    logic [NTHR-1:0][THR_BITS-1:0] act_prev_m;  // active one edge earlier

    int               exp_env_a;
    int               exp_env_b;
    int               prev_env_a;
    int               prev_env_b;
    logic [NTRIG-1:0] exp_trig;
    logic             rst_d1 = 1'b0;  // reset seen one edge back
    logic             rst_d2 = 1'b0;
    logic             failed = 1'b0;
    string            test_name;
    int               cur_tag;

    dual_beam_trigger dut (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .beam_a_i        (beam_a_i),
        .beam_a_use_i    (beam_a_use_i),
        .beam_a_invert_i (beam_a_invert_i),
        .beam_b_i        (beam_b_i),
        .beam_b_use_i    (beam_b_use_i),
        .beam_b_invert_i (beam_b_invert_i),
        .thresh_i        (thresh_i),
        .thresh_wr_i     (thresh_wr_i),
        .thresh_update_i (thresh_update_i),
        .trigger_o       (trigger_o),
        .env_a_o         (env_a_o),
        .env_b_o         (env_b_o)
    );

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    // record what the DUT took at each edge, zero history under reset
    always @(posedge clk_i) begin
        rst_d1 <= rst_i;
        rst_d2 <= rst_d1;
        if (rst_i) begin
            for (int k = 0; k < HIST; k++) begin
                word_a_h[k] <= '0;
                use_a_h[k]  <= '0;
                inv_a_h[k]  <= '0;
                word_b_h[k] <= '0;
                use_b_h[k]  <= '0;
                inv_b_h[k]  <= '0;
                tag_h[k]    <= TAG_NONE;
            end
            pend_m     <= {NTHR{THR_RESET}};
            act_m      <= {NTHR{THR_RESET}};
            act_prev_m <= {NTHR{THR_RESET}};
        end else begin
            for (int k = HIST-1; k > 0; k--) begin
                word_a_h[k] <= word_a_h[k-1];
                use_a_h[k]  <= use_a_h[k-1];
                inv_a_h[k]  <= inv_a_h[k-1];
                word_b_h[k] <= word_b_h[k-1];
                use_b_h[k]  <= use_b_h[k-1];
                inv_b_h[k]  <= inv_b_h[k-1];
                tag_h[k]    <= tag_h[k-1];
            end
            word_a_h[0] <= beam_a_i;
            use_a_h[0]  <= beam_a_use_i;
            inv_a_h[0]  <= beam_a_invert_i;
            word_b_h[0] <= beam_b_i;
            use_b_h[0]  <= beam_b_use_i;
            inv_b_h[0]  <= beam_b_invert_i;
            tag_h[0]    <= cur_tag;
            act_prev_m  <= act_m;
            for (int j = 0; j < NTHR; j++) begin
                if (thresh_update_i[j])
                    act_m[j] <= pend_m[j];   // old pending moves on update
                if (thresh_wr_i[j])
                    pend_m[j] <= thresh_i[j];
            end
        end
    end

    // env at n+4 covers words n and n-1, trigger at n+5 one word further
    always_comb begin
        exp_env_a  = model_envelope(word_a_h[3], use_a_h[3], inv_a_h[3],
                                    word_a_h[4], use_a_h[4], inv_a_h[4]);
        exp_env_b  = model_envelope(word_b_h[3], use_b_h[3], inv_b_h[3],
                                    word_b_h[4], use_b_h[4], inv_b_h[4]);
        prev_env_a = model_envelope(word_a_h[4], use_a_h[4], inv_a_h[4],
                                    word_a_h[5], use_a_h[5], inv_a_h[5]);
        prev_env_b = model_envelope(word_b_h[4], use_b_h[4], inv_b_h[4],
                                    word_b_h[5], use_b_h[5], inv_b_h[5]);
        exp_trig   = model_triggers(prev_env_a, prev_env_b, act_prev_m[0], act_prev_m[1]);
    end

    task automatic report_mismatch(input string what, input int expected, input int actual);
        failed = 1'b1;
        $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
        $display("Simulation failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    a_reset_quiet: assert property (@(posedge clk_i)
        (rst_d1 || rst_d2) |-> (trigger_o == '0 && env_a_o == '0 && env_b_o == '0)
    ) else report_mismatch("outputs under reset", 0,
                           int'({$sampled(trigger_o), $sampled(env_a_o) | $sampled(env_b_o)}));

    a_env_a_match: assert property (@(posedge clk_i) disable iff (rst_i)
        int'(env_a_o) == exp_env_a
    ) else report_mismatch("env_a_o", $sampled(exp_env_a), int'($sampled(env_a_o)));

    a_env_b_match: assert property (@(posedge clk_i) disable iff (rst_i)
        int'(env_b_o) == exp_env_b
    ) else report_mismatch("env_b_o", $sampled(exp_env_b), int'($sampled(env_b_o)));

    a_trigger_match: assert property (@(posedge clk_i) disable iff (rst_i)
        trigger_o == exp_trig
    ) else report_mismatch("trigger_o", int'($sampled(exp_trig)), int'($sampled(trigger_o)));

    // passing +15 and inverting -15 must look identical
    a_mirror_equal: assert property (@(posedge clk_i) disable iff (rst_i)
        (tag_h[3] == TAG_MIRROR && tag_h[4] == TAG_MIRROR) |-> env_a_o == env_b_o
    ) else report_mismatch("mirrored beams", int'($sampled(env_a_o)), int'($sampled(env_b_o)));

    task automatic next_cycle();
        @(posedge clk_i);
        #(DRIVE_DLY);
    endtask

    // every sample of every channel set to v
    function automatic logic [IN_BITS-1:0] fill_word(input int v);
        logic [IN_BITS-1:0] w;
        for (int k = 0; k < NCHAN*NSAMP; k++)
            w[k*NBITS +: NBITS] = NBITS'(v);
        return w;
    endfunction

    function automatic logic [IN_BITS-1:0] random_word();
        logic [IN_BITS-1:0] w;
        for (int k = 0; k < IN_BITS; k += 32)
            w[k +: 32] = $urandom();
        return w;
    endfunction

    task automatic stage_threshold(input int slot, input logic [THR_BITS-1:0] value,
                                   input logic with_update);
        thresh_i[slot]        = value;
        thresh_wr_i[slot]     = 1'b1;
        thresh_update_i[slot] = with_update;  // same-cycle update moves the old pending
        next_cycle();
        thresh_wr_i     = '0;
        thresh_update_i = '0;
    endtask

    task automatic commit_thresholds(input logic [NTHR-1:0] slots);
        thresh_update_i = slots;
        next_cycle();
        thresh_update_i = '0;
    endtask

    // bounded wait for a trigger pattern, sampled after the edge
    task automatic wait_for_trigger(input logic [NTRIG-1:0] pattern);
        int cycles;
        cycles = 0;
        while (trigger_o !== pattern && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (trigger_o !== pattern) begin
            $display("timeout: trigger_o stayed %b, never reached %b within %0d cycles in %s",
                     trigger_o, pattern, WAIT_LIMIT, test_name);
            $display("Simulation failed");
            $fatal(1, "wait for trigger timed out");
        end
    endtask

    initial begin : stimulus
        int ch;
        void'($urandom(SEED));
        clk_i           = 1'b0;
        rst_i           = 1'b1;
        beam_a_i        = '0;
        beam_a_use_i    = '0;
        beam_a_invert_i = '0;
        beam_b_i        = '0;
        beam_b_use_i    = '0;
        beam_b_invert_i = '0;
        thresh_i        = '0;
        thresh_wr_i     = '0;
        thresh_update_i = '0;
        cur_tag         = TAG_NONE;
        test_name       = "reset";
        repeat (RST_CYCLES) @(posedge clk_i);
        #(DRIVE_DLY);
        rst_i = 1'b0;

        // full scale on both beams, reset thresholds keep everything quiet
        beam_a_i        = fill_word(-16);
        beam_a_use_i    = '1;
        beam_a_invert_i = '1;  // -16 inverted, +128 per sample
        beam_b_i        = fill_word(-16);
        beam_b_use_i    = '1;
        repeat (8) next_cycle();

        test_name = "random envelope";
        repeat (40) begin
            beam_a_i        = random_word();
            beam_a_use_i    = NCHAN'($urandom());
            beam_a_invert_i = NCHAN'($urandom());
            beam_b_i        = random_word();
            beam_b_use_i    = NCHAN'($urandom());
            beam_b_invert_i = NCHAN'($urandom());
            next_cycle();
        end

        test_name    = "masking";
        beam_a_use_i = '0;  // all off, data should not matter
        beam_b_use_i = '0;
        repeat (6) begin
            beam_a_i = random_word();
            beam_b_i = random_word();
            next_cycle();
        end
        cur_tag         = TAG_MIRROR;
        beam_a_i        = fill_word(15);
        beam_a_use_i    = '1;
        beam_a_invert_i = '0;
        beam_b_i        = fill_word(-15);
        beam_b_use_i    = '1;
        beam_b_invert_i = '1;
        repeat (7) next_cycle();
        cur_tag = TAG_NONE;
        repeat (3) begin  // one channel alone on each beam
            ch              = $urandom_range(NCHAN-1, 0);
            beam_a_use_i    = NCHAN'(1) << ch;
            beam_a_invert_i = NCHAN'($urandom());
            beam_b_use_i    = NCHAN'(1) << (NCHAN-1-ch);
            beam_b_invert_i = NCHAN'($urandom());
            repeat (4) begin
                beam_a_i = random_word();
                beam_b_i = random_word();
                next_cycle();
            end
        end

        test_name       = "double buffer";
        beam_a_i        = fill_word(1);  // +8 per sample, envelope 512
        beam_a_use_i    = '1;
        beam_a_invert_i = '0;
        beam_b_use_i    = '0;
        stage_threshold(0, 100, 1'b0);
        repeat (8) next_cycle();  // staged only, still quiet
        commit_thresholds(2'b01);
        wait_for_trigger(4'b0001);
        stage_threshold(1, 300, 1'b1);  // active 1 takes the reset value
        repeat (6) next_cycle();
        commit_thresholds(2'b10);
        wait_for_trigger(4'b0101);

        test_name       = "trigger mapping";
        beam_a_i        = fill_word(2);  // envelope 2048
        beam_b_i        = fill_word(1);  // envelope 512
        beam_b_use_i    = '1;
        beam_b_invert_i = '0;
        stage_threshold(0, 1000, 1'b0);
        stage_threshold(1, 2048, 1'b0);  // A sits exactly on it
        commit_thresholds(2'b11);
        wait_for_trigger(4'b0001);
        stage_threshold(1, 511, 1'b0);
        commit_thresholds(2'b10);
        wait_for_trigger(4'b1101);
        stage_threshold(0, 511, 1'b0);
        commit_thresholds(2'b01);
        wait_for_trigger(4'b1111);
        stage_threshold(0, 512, 1'b0);  // B equal to thr0, bit 1 drops
        commit_thresholds(2'b01);
        wait_for_trigger(4'b1101);
        repeat (4) next_cycle();

        beam_a_i = '0;
        beam_b_i = '0;
        repeat (8) next_cycle();
        if (!failed) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+testbench
source/beam_cfg_pkg.sv
source/trig_ctrl_pkg.sv
source/beam_former.sv
source/beam_envelope.sv
source/beam_threshold.sv
source/dual_beam_trigger.sv
testbench/tb_dual_beam_trigger.sv

//--- Bender.yml
package:
  name: dual_beam_trigger

sources:
  # packages first, then the pipeline stages, then the top level
  - source/beam_cfg_pkg.sv
  - source/trig_ctrl_pkg.sv
  - source/beam_former.sv
  - source/beam_envelope.sv
  - source/beam_threshold.sv
  - source/dual_beam_trigger.sv

  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_dual_beam_trigger.sv
